/* tb/i2s_input.dat */
// columns: strobe count (0 none, 1 one, 2 decoy then real), left, right,
// expected left word, expected right word; one row per frame
0000 0000 0000 0000 0000
0000 0000 0000 0000 0000
0001 1234 abcd 1234 abcd
0001 8001 7ffe 8001 7ffe
0002 5a5a a5a5 5a5a a5a5
0000 0000 0000 0000 0000
0001 ffff 0001 ffff 0001
0002 0f0f f0f0 0f0f f0f0
0001 8000 7fff 8000 7fff
0000 1111 2222 0000 0000
0001 c3a5 1e2d c3a5 1e2d
0001 0001 8000 0001 8000

/* vlog.f */
+incdir+hw
hw/i2s_pkg.sv
hw/i2s_bit_clock.sv
hw/i2s_sample_latch.sv
hw/i2s_channel_slot.sv
hw/i2s_serializer.sv
hw/i2s_tx.sv
tb/i2s_tx_assert.sv
tb/i2s_tx_tb.sv

/* Makefile */
# Verilator simulation of the i2s transmitter

VERILATOR ?= verilator
TOP       ?= i2s_tx_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/i2s_tx_tb.sv */
//////////////////////////////////////////////////
// i2s transmitter testbench
// file-driven stereo samples, i2s deserializer on
// the output pins, frame and underrun checks
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module i2s_tx_tb;

  localparam int NUM_ROWS  = 12;
  localparam int ROW_W     = 5;
  localparam int CLK_HALF  = 4;
  localparam int WAIT_MAX  = 600;

  logic        clk;
  logic        rst;
  logic [15:0] sample_l;
  logic [15:0] sample_r;
  logic        sample_valid;
  wire         sclk;
  wire         lrck;
  wire         dac;
  wire         underrun;

  // strobe count, left, right, expected left, expected right
  logic [15:0] rows [NUM_ROWS*ROW_W];

  // deserializer state
  logic [31:0] ser_shreg;
  int          ser_cnt;
  logic        ser_prev_lrck;
  logic        ser_seen_change;
  logic [15:0] last_left;
  logic [15:0] last_right;
  int          right_cnt;
  int          underrun_cnt;
  int          err_cnt;

  i2s_tx DUT (
    .i_clk          (clk),
    .i_rst          (rst),
    .i_sample_l     (sample_l),
    .i_sample_r     (sample_r),
    .i_sample_valid (sample_valid),
    .o_sclk         (sclk),
    .o_lrck         (lrck),
    .o_dac          (dac),
    .o_underrun     (underrun)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  ////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      err_cnt = err_cnt + 1;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("sim failed");
    $fatal(1);
  endtask

  // returns just after the edge where lrck falls, i.e. a frame start
  task automatic wait_frame_start();
    int   n;
    logic prev;
    n    = 0;
    prev = lrck;
    @(negedge clk);
    while (!(prev == 1'b1 && lrck == 1'b0)) begin
      prev = lrck;
      n    = n + 1;
      if (n > WAIT_MAX) begin
        stop_on_timeout("a frame start on lrck");
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_right_slots(input int target);
    int n;
    n = 0;
    while (right_cnt < target) begin
      n = n + 1;
      if (n > 2 * WAIT_MAX) begin
        stop_on_timeout("a received right slot");
      end
      @(negedge clk);
    end
  endtask

  task automatic send_sample(input logic [15:0] l, input logic [15:0] r);
    @(posedge clk);
    #1;
    sample_l     = l;
    sample_r     = r;
    sample_valid = 1'b1;
    @(posedge clk);
    #1;
    sample_valid = 1'b0;
  endtask

  ////////////////////////////////////////////////
  // monitors
  ////////////////////////////////////////////////

  // underrun is combinational, stable at the falling clock edge
  always @(negedge clk) begin
    if (!rst && underrun) begin
      underrun_cnt <= underrun_cnt + 1;
    end
  end

  // i2s receiver, a slot closes on the rise where lrck has changed
  always @(posedge sclk) begin
    if (!rst) begin
      ser_shreg = {ser_shreg[30:0], dac};
      ser_cnt   = ser_cnt + 1;
      if (lrck != ser_prev_lrck) begin
        if (ser_seen_change) begin
          check("slot length", 32, ser_cnt);
          check("slot pad", 32'h0, {16'h0, ser_shreg[15:0]});
          if (ser_prev_lrck) begin
            last_right = ser_shreg[31:16];
            right_cnt  = right_cnt + 1;
          end else begin
            last_left = ser_shreg[31:16];
          end
        end
        ser_seen_change = 1'b1;
        ser_cnt         = 0;
      end
      ser_prev_lrck = lrck;
    end
  end

  ////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////

  initial begin
    int          row;
    int          gap;
    int          base_ur;
    int          base_right;
    logic [15:0] cnt;
    logic [15:0] in_l;
    logic [15:0] in_r;
    logic [15:0] exp_l;
    logic [15:0] exp_r;

    rst             = 1'b1;
    sample_l        = '0;
    sample_r        = '0;
    sample_valid    = 1'b0;
    ser_shreg       = '0;
    ser_cnt         = 0;
    ser_prev_lrck   = 1'b0;
    ser_seen_change = 1'b0;
    last_left       = '0;
    last_right      = '0;
    right_cnt       = 0;
    underrun_cnt    = 0;
    err_cnt         = 0;
    gap             = $urandom(32'h9762_2775);

    $readmemh("tb/i2s_input.dat", rows);

    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    // first frame start that lrck shows is the second one
    wait_frame_start();

    for (row = 0; row < NUM_ROWS; row++) begin
      cnt   = rows[row*ROW_W + 0];
      in_l  = rows[row*ROW_W + 1];
      in_r  = rows[row*ROW_W + 2];
      exp_l = rows[row*ROW_W + 3];
      exp_r = rows[row*ROW_W + 4];

      base_ur = underrun_cnt;
      // idle gap stays well inside the current frame
      gap = $urandom % 180;
      repeat (gap) @(posedge clk);
      if (cnt == 16'd2) begin
        // decoy that the second strobe must replace
        send_sample(~in_l, ~in_r);
        gap = $urandom % 20;
        repeat (gap) @(posedge clk);
      end
      if (cnt != 16'd0) begin
        send_sample(in_l, in_r);
      end

      // frame that carries this row
      wait_frame_start();
      base_right = right_cnt;
      check($sformatf("row %0d underrun", row), (cnt == 16'd0) ? 32'd1 : 32'd0,
            underrun_cnt - base_ur);

      // previous right slot closes first, then this frame's right slot
      wait_right_slots(base_right + 2);
      check($sformatf("row %0d left word", row), {16'h0, exp_l}, {16'h0, last_left});
      check($sformatf("row %0d right word", row), {16'h0, exp_r}, {16'h0, last_right});
    end

    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/i2s_tx_assert.sv */
//////////////////////////////////////////////////
// i2s transmitter assertions
// bit clock period and frame structure on pins
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module i2s_tx_assert (
  input wire i_clk,
  input wire i_rst,
  input wire o_sclk,
  input wire o_lrck,
  input wire o_underrun
);

  // bit clock repeats every 4 master clocks
  a_sclk_period: assert property (@(posedge i_clk) disable iff (i_rst)
    $rose(o_sclk) |-> ##4 $rose(o_sclk))
    else $error("sclk period is not 4 cycles");

  // half frame is 32 bits of 4 cycles
  a_lrck_half: assert property (@(posedge i_clk) disable iff (i_rst)
    $changed(o_lrck) |-> ##128 $changed(o_lrck))
    else $error("lrck half frame is not 128 cycles");

  a_lrck_edge: assert property (@(posedge i_clk) disable iff (i_rst)
    $changed(o_lrck) |-> $fell(o_sclk))
    else $error("lrck moved away from a falling sclk");

  a_underrun_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
    o_underrun |=> !o_underrun)
    else $error("underrun held longer than one cycle");

endmodule

bind i2s_tx i2s_tx_assert u_assert (
  .i_clk      (i_clk),
  .i_rst      (i_rst),
  .o_sclk     (o_sclk),
  .o_lrck     (o_lrck),
  .o_underrun (o_underrun)
);

`default_nettype wire

/* hw/i2s_tx.sv */
//////////////////////////////////////////////////
// i2s audio transmitter
// 48 kHz stereo, 16 active bits in 32-bit slots,
// run from the 12.288 MHz master clock
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "i2s_macros.svh"

module i2s_tx (
  input  wire               i_clk,
  input  wire               i_rst,
  input  i2s_pkg::sample_t  i_sample_l,
  input  i2s_pkg::sample_t  i_sample_r,
  input  wire               i_sample_valid,
  output logic              o_sclk,
  output logic              o_lrck,
  output logic              o_dac,
  output logic              o_underrun
);

  import i2s_pkg::*;

  logic                     bit_en;
  logic                     frame_start;
  chan_t                    chan;
  logic                     load;
  sample_t                  slot_l;
  sample_t                  slot_r;
  sample_t                  slot_sample [`I2S_NUM_CHAN];
  logic [`I2S_NUM_CHAN-1:0] slot_msb;

  ////////////////////////////////////////////////
  // timing
  ////////////////////////////////////////////////

  i2s_bit_clock u_bit_clock (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .o_sclk        (o_sclk),
    .o_bit_en      (bit_en),
    .o_frame_start (frame_start),
    .o_chan        (chan)
  );

  ////////////////////////////////////////////////
  // sample path
  ////////////////////////////////////////////////

  i2s_sample_latch u_sample_latch (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_sample_l     (i_sample_l),
    .i_sample_r     (i_sample_r),
    .i_sample_valid (i_sample_valid),
    .i_frame_start  (frame_start),
    .o_load         (load),
    .o_slot_l       (slot_l),
    .o_slot_r       (slot_r),
    .o_underrun     (o_underrun)
  );

  // slot index follows chan_t
  assign slot_sample[CHAN_LEFT]  = slot_l;
  assign slot_sample[CHAN_RIGHT] = slot_r;

  // one shift register per channel
  for (genvar i = 0; i < `I2S_NUM_CHAN; i++) begin : g_slot
    i2s_channel_slot #(
      .CHAN (chan_t'(i))
    ) u_slot (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_load   (load),
      .i_sample (slot_sample[i]),
      .i_bit_en (bit_en),
      .i_chan   (chan),
      .o_msb    (slot_msb[i])
    );
  end

  i2s_serializer u_serializer (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_bit_en (bit_en),
    .i_chan   (chan),
    .i_msb    (slot_msb),
    .o_lrck   (o_lrck),
    .o_dac    (o_dac)
  );

endmodule

`default_nettype wire

/* hw/i2s_serializer.sv */
//////////////////////////////////////////////////
// i2s serializer
// drives lrck and the data pin, data trailing
// lrck by one bit period
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "i2s_macros.svh"

module i2s_serializer (
  input  wire                      i_clk,
  input  wire                      i_rst,
  input  wire                      i_bit_en,
  input  i2s_pkg::chan_t           i_chan,
  input  wire [`I2S_NUM_CHAN-1:0]  i_msb,
  output logic                     o_lrck,
  output logic                     o_dac
);

  import i2s_pkg::*;

  // channel of the bit period in progress, also the lrck level
  chan_t chan_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      chan_q <= CHAN_LEFT;
      o_dac  <= 1'b0;
    end else if (i_bit_en) begin
      // bit from the channel that owned the period just ended
      o_dac  <= i_msb[chan_q];
      chan_q <= i_chan;
    end
  end

  // low for left
  assign o_lrck = chan_q;

endmodule

`default_nettype wire

/* hw/i2s_channel_slot.sv */
//////////////////////////////////////////////////
// i2s channel slot
// 32-bit shift register for one channel, sample in
// the upper half and zero pad below
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "i2s_macros.svh"

module i2s_channel_slot #(
  parameter i2s_pkg::chan_t CHAN = i2s_pkg::CHAN_LEFT
) (
  input  wire               i_clk,
  input  wire               i_rst,
  input  wire               i_load,
  input  i2s_pkg::sample_t  i_sample,
  input  wire               i_bit_en,
  input  i2s_pkg::chan_t    i_chan,
  output logic              o_msb
);

  import i2s_pkg::*;

  localparam int PAD_W = `I2S_SLOT_W - `I2S_SAMPLE_W;

  logic [`I2S_SLOT_W-1:0] shreg;
  // this channel owns the bit period now ending
  logic                   own_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      own_q <= 1'b0;
      shreg <= '0;
    end else begin
      if (i_bit_en) begin
        own_q <= (i_chan == CHAN);
      end
      // load wins over the shift on frame start
      if (i_load) begin
        shreg <= {i_sample, {PAD_W{1'b0}}};
      end else if (i_bit_en && own_q) begin
        // serializer takes the msb on this same edge
        shreg <= {shreg[`I2S_SLOT_W-2:0], 1'b0};
      end
    end
  end

  assign o_msb = shreg[`I2S_SLOT_W-1];

endmodule

`default_nettype wire

/* hw/i2s_sample_latch.sv */
//////////////////////////////////////////////////
// i2s sample latch
// holds the newest stereo sample until frame start
// and flags an underrun when none arrived
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module i2s_sample_latch (
  input  wire               i_clk,
  input  wire               i_rst,
  input  i2s_pkg::sample_t  i_sample_l,
  input  i2s_pkg::sample_t  i_sample_r,
  input  wire               i_sample_valid,
  input  wire               i_frame_start,
  output logic              o_load,
  output i2s_pkg::sample_t  o_slot_l,
  output i2s_pkg::sample_t  o_slot_r,
  output logic              o_underrun
);

  import i2s_pkg::*;

  // pending pair, later strobes overwrite
  sample_t pend_l;
  sample_t pend_r;
  logic    pend_valid;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pend_valid <= 1'b0;
    end else if (i_sample_valid) begin
      // strobe on frame start belongs to the next frame
      pend_valid <= 1'b1;
    end else if (i_frame_start) begin
      pend_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_sample_valid) begin
      pend_l <= i_sample_l;
      pend_r <= i_sample_r;
    end
  end

  // slots load together with frame start
  assign o_load     = i_frame_start;
  // silence when nothing is pending
  assign o_slot_l   = pend_valid ? pend_l : '0;
  assign o_slot_r   = pend_valid ? pend_r : '0;
  assign o_underrun = i_frame_start && !pend_valid;

endmodule

`default_nettype wire

/* hw/i2s_bit_clock.sv */
//////////////////////////////////////////////////
// i2s bit clock and frame timing
// divides the master clock into the bit clock and
// counts 64 bit periods per stereo frame
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "i2s_macros.svh"

module i2s_bit_clock (
  input  wire             i_clk,
  input  wire             i_rst,
  output logic            o_sclk,
  output logic            o_bit_en,
  output logic            o_frame_start,
  output i2s_pkg::chan_t  o_chan
);

  import i2s_pkg::*;

  localparam int DIV_W     = $clog2(`I2S_SCLK_DIV);
  localparam int FRAME_LEN = `I2S_SLOT_W * `I2S_NUM_CHAN;
  localparam int CNT_W     = $clog2(FRAME_LEN);

  // master clock phase within one bit period
  logic [DIV_W-1:0] div_cnt;
  // bit period index within the frame, wraps at 64
  logic [CNT_W-1:0] bit_cnt;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      div_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      if (div_cnt == DIV_W'(`I2S_SCLK_DIV - 1)) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      // advance once per bit period
      if (o_bit_en) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // low for phases 0..1, high for 2..3
  assign o_sclk        = div_cnt[DIV_W-1];
  // last high phase, sclk falls at the end of this cycle
  assign o_bit_en      = (div_cnt == DIV_W'(`I2S_SCLK_DIV - 1));
  // bit_en that begins bit 0
  assign o_frame_start = o_bit_en && (bit_cnt == '0);
  // bits 0..31 left, 32..63 right
  assign o_chan        = chan_t'(bit_cnt[CNT_W-1]);

endmodule

`default_nettype wire

/* hw/i2s_pkg.sv */
//////////////////////////////////////////////////
// i2s transmitter types
// channel select and audio sample word
//////////////////////////////////////////////////

`default_nettype none

`include "i2s_macros.svh"

package i2s_pkg;

  // slot index and lrck level, left channel while lrck is low
  typedef enum logic {
    CHAN_LEFT  = 1'b0,
    CHAN_RIGHT = 1'b1
  } chan_t;

  // two's complement pcm word
  typedef logic signed [`I2S_SAMPLE_W-1:0] sample_t;

endpackage

`default_nettype wire

/* hw/i2s_macros.svh */
//////////////////////////////////////////////////
// i2s transmitter sizes
// sample, slot and frame widths plus the
// master clock to bit clock ratio
//////////////////////////////////////////////////

`ifndef I2S_MACROS_SVH
`define I2S_MACROS_SVH

// active bits per sample, one 16-bit word
`define I2S_SAMPLE_W 16

// bits per channel slot, active bits then zero pad
`define I2S_SLOT_W 32

// stereo frame, left then right
`define I2S_NUM_CHAN 2

// master clocks per bit period, 12.288 MHz down to 3.072 MHz
`define I2S_SCLK_DIV 4

`endif
